/* include/zx_ports_config.svh */
`ifndef ZX_PORTS_CONFIG_SVH
`define ZX_PORTS_CONFIG_SVH

// low address bytes of the decoded ports
`define ZXP_PORT_FE     8'hFE
`define ZXP_PORT_FD     8'hFD   // 7FFD paging and the AY pair
`define ZXP_PORT_F7     8'hF7   // EFF7
`define ZXP_PORT_KJOY   8'h1F
`define ZXP_PORT_SDCFG  8'h77
`define ZXP_PORT_SDDAT  8'h57

// fetches from this high byte enter TR-DOS
`define ZXP_DOS_PAGE    8'h3D

// clk cycles per sclk half period, 1 or more
`define ZXP_SPI_DIV     2

`endif

/* verilog/zx_ports_pkg.sv */
`default_nettype none

package zx_ports_pkg;

	// one sample of the Z80 bus
	typedef struct packed {
		logic [15:0] a;
		logic [7:0]  din;
		logic        iorq_n;
		logic        mreq_n;
		logic        m1_n;
		logic        rd_n;
		logic        wr_n;
	} z80_bus_t;

	typedef enum logic [2:0] {
		PORT_NONE,
		PORT_FE,
		PORT_7FFD,
		PORT_AY,     // answered by the AY chip itself
		PORT_EFF7,
		PORT_KJOY,
		PORT_SDCFG,
		PORT_SDDAT
	} port_sel_e;

	// decoded access, wr/rd are single cycle pulses
	typedef struct packed {
		port_sel_e   sel;
		logic        wr;
		logic        rd;
		logic        hit;
		logic        external;
		logic [7:0]  data;
	} port_acc_t;

	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_SHIFT,
		SPI_DONE
	} spi_state_e;

endpackage

`default_nettype wire

/* verilog/zx_ports_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zx_ports_config.svh"

module zx_ports_decode
	import zx_ports_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n,
	input  z80_bus_t  bus,
	input  wire       dos,
	output port_acc_t acc
);

	logic      io_wr;
	logic      io_rd;
	logic      iowr_q;   // strobe state seen at the last edge
	logic      iord_q;
	logic      wr_q;
	logic      rd_q;
	port_sel_e sel;

	assign io_wr = !bus.iorq_n && !bus.wr_n;
	assign io_rd = !bus.iorq_n && !bus.rd_n;

	// one pulse per strobe, however long it is held
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_q <= 1'b0;
			iord_q <= 1'b0;
			wr_q   <= 1'b0;
			rd_q   <= 1'b0;
		end
		else
		begin
			iowr_q <= io_wr;
			iord_q <= io_rd;
			wr_q   <= io_wr && !iowr_q;
			rd_q   <= io_rd && !iord_q;
		end
	end

	// port map on the low address byte
	always_comb
	begin
		case (bus.a[7:0])
			`ZXP_PORT_FE:    sel = PORT_FE;
			`ZXP_PORT_FD:    sel = bus.a[15] ? PORT_AY : PORT_7FFD;
			`ZXP_PORT_F7:    sel = bus.a[12] ? PORT_NONE : PORT_EFF7;
			`ZXP_PORT_KJOY:  sel = dos ? PORT_NONE : PORT_KJOY; // hidden under DOS
			`ZXP_PORT_SDCFG: sel = PORT_SDCFG;
			`ZXP_PORT_SDDAT: sel = PORT_SDDAT;
			default:         sel = PORT_NONE;
		endcase
	end

	always_comb
	begin
		acc.sel      = sel;
		acc.wr       = wr_q;
		acc.rd       = rd_q;
		acc.hit      = (sel != PORT_NONE);
		acc.external = (sel == PORT_AY);
		acc.data     = bus.din;
	end

	// a cycle is either IN or OUT, never both
	a_wr_rd_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(wr_q && rd_q))
		else $error("decode: wr and rd pulses overlap");

endmodule

`default_nettype wire

/* verilog/zx_ports_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zx_ports_config.svh"

module zx_ports_regs
	import zx_ports_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  z80_bus_t   bus,
	input  port_acc_t  acc,
	input  wire  [4:0] keys_in,
	input  wire  [4:0] kj_in,
	output logic [7:0] dout,
	output logic       dataout,
	output logic [2:0] border,
	output logic       beep,
	output logic       dos,
	output logic [7:0] p7ffd,
	output logic [7:0] peff7,
	output logic       ay_bdir,
	output logic       ay_bc1,
	output logic       sd_cs_n,
	output logic       sd_req,
	output logic [7:0] sd_tx,
	input  wire        sd_ack,
	input  wire  [7:0] sd_rx
);

	logic [7:0] p7ffd_q;
	logic [7:0] peff7_q;
	logic [7:0] sd_rx_q;   // last byte from the card
	logic       lock_7ffd;
	logic       sd_busy;
	logic       sd_start;

	assign lock_7ffd = p7ffd_q[5] && peff7_q[2]; // 48k lock, only with 1M blocked

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border  <= 3'd0;
			beep    <= 1'b0;
			p7ffd_q <= 8'h00;
			peff7_q <= 8'h00;
			sd_cs_n <= 1'b1;
		end
		else if (acc.wr)
		begin
			case (acc.sel)
				PORT_FE:
				begin
					border <= acc.data[2:0];
					beep   <= acc.data[4];
				end
				PORT_7FFD:
					if (!lock_7ffd)
						p7ffd_q <= acc.data;
				PORT_EFF7:  peff7_q <= acc.data;
				PORT_SDCFG: sd_cs_n <= acc.data[1];
				default:    ;
			endcase
		end
	end

	// bits 7..5 are masked while EFF7 bit 2 blocks the upper megabyte
	assign p7ffd = {(peff7_q[2] ? 3'b000 : p7ffd_q[7:5]), p7ffd_q[4:0]};
	assign peff7 = peff7_q;

	// TR-DOS trap on opcode fetches
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (!bus.mreq_n && !bus.m1_n)
		begin
			if (bus.a[15:8] == `ZXP_DOS_PAGE && p7ffd_q[4])
				dos <= 1'b1;
			else if (bus.a[15:14] != 2'b00)
				dos <= 1'b0; // back in RAM
		end
	end

	// SD data port, requester side of the req/ack pair
	assign sd_busy  = sd_req || sd_ack;
	assign sd_start = (acc.wr || acc.rd) && (acc.sel == PORT_SDDAT) && !sd_busy;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sd_req  <= 1'b0;
			sd_tx   <= 8'hFF;
			sd_rx_q <= 8'hFF;
		end
		else if (sd_start)
		begin
			sd_req <= 1'b1;
			sd_tx  <= acc.wr ? acc.data : 8'hFF; // a read clocks out FF
		end
		else if (sd_req && sd_ack)
		begin
			sd_req  <= 1'b0;
			sd_rx_q <= sd_rx;
		end
	end

	always_comb
	begin
		case (acc.sel)
			PORT_FE:    dout = {3'b101, keys_in};
			PORT_KJOY:  dout = {3'b000, kj_in};
			PORT_SDCFG: dout = {sd_busy, 7'd0};
			PORT_SDDAT: dout = sd_rx_q;
			default:    dout = 8'hFF;
		endcase
	end

	assign dataout = acc.hit && !acc.external && !bus.iorq_n && !bus.rd_n;

	// AY: FFFD selects the register, BFFD carries data
	assign ay_bdir = (acc.sel == PORT_AY) && !bus.iorq_n && !bus.wr_n;
	assign ay_bc1  = (acc.sel == PORT_AY) && bus.a[14] && !bus.iorq_n
		&& (!bus.rd_n || !bus.wr_n);

	// req is only withdrawn once the SPI side has acknowledged
	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(sd_req) |-> $past(sd_ack))
		else $error("regs: sd_req dropped before sd_ack");

endmodule

`default_nettype wire

/* verilog/zx_sd_spi.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zx_ports_config.svh"

module zx_sd_spi
	import zx_ports_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire        sd_req,
	input  wire  [7:0] sd_tx,
	output logic       sd_ack,
	output logic [7:0] sd_rx,
	output logic       sd_sclk,
	output logic       sd_mosi,
	input  wire        sd_miso
);

	localparam int DIV = `ZXP_SPI_DIV;
	localparam int DW  = (DIV > 1) ? $clog2(DIV) : 1;

	spi_state_e  state;
	logic [DW-1:0] div_cnt;
	logic [2:0]  bit_cnt;
	logic [7:0]  shreg;    // tx bits out the top, rx bits in at the bottom
	logic        miso_bit; // sampled on the rising sclk edge
	logic        half_end;

	assign half_end = (div_cnt == DW'(DIV - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= SPI_IDLE;
			div_cnt  <= '0;
			bit_cnt  <= 3'd0;
			shreg    <= 8'hFF;
			miso_bit <= 1'b1;
			sd_sclk  <= 1'b0;
			sd_ack   <= 1'b0;
		end
		else
		begin
			case (state)
				SPI_IDLE:
					if (sd_req)
					begin
						shreg   <= sd_tx;
						div_cnt <= '0;
						bit_cnt <= 3'd0;
						sd_sclk <= 1'b0;
						state   <= SPI_SHIFT;
					end
				SPI_SHIFT:
					if (!half_end)
						div_cnt <= div_cnt + 1'b1;
					else
					begin
						div_cnt <= '0;
						sd_sclk <= !sd_sclk;
						if (!sd_sclk)
							miso_bit <= sd_miso; // rising edge
						else
						begin
							shreg   <= {shreg[6:0], miso_bit};
							bit_cnt <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7)
								state <= SPI_DONE;
						end
					end
				SPI_DONE:
					if (!sd_ack)
						sd_ack <= 1'b1;
					else if (!sd_req)
					begin
						sd_ack <= 1'b0;
						state  <= SPI_IDLE;
					end
				default: state <= SPI_IDLE;
			endcase
		end
	end

	assign sd_rx   = shreg;
	assign sd_mosi = (state == SPI_SHIFT) ? shreg[7] : 1'b1; // line idles high

	a_ack_on_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(sd_ack) |-> sd_req)
		else $error("spi: sd_ack raised without sd_req");

endmodule

`default_nettype wire

/* verilog/zx_ports_top.sv */
`timescale 1ns/1ps
`default_nettype none

module zx_ports_top
	import zx_ports_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  z80_bus_t   bus,
	input  wire  [4:0] keys_in,
	input  wire  [4:0] kj_in,
	input  wire        sd_miso,
	output wire  [7:0] dout,
	output wire        dataout,
	output wire  [2:0] border,
	output wire        beep,
	output wire        dos,
	output wire  [7:0] p7ffd,
	output wire  [7:0] peff7,
	output wire        ay_bdir,
	output wire        ay_bc1,
	output wire        sd_cs_n,
	output wire        sd_sclk,
	output wire        sd_mosi
);

	port_acc_t  acc;
	wire        sd_req;
	wire  [7:0] sd_tx;
	wire        sd_ack;
	wire  [7:0] sd_rx;

	zx_ports_decode i_decode (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (bus),
		.dos   (dos),     // hides the joystick port
		.acc   (acc)
	);

	zx_ports_regs i_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.bus     (bus),
		.acc     (acc),
		.keys_in (keys_in),
		.kj_in   (kj_in),
		.dout    (dout),
		.dataout (dataout),
		.border  (border),
		.beep    (beep),
		.dos     (dos),
		.p7ffd   (p7ffd),
		.peff7   (peff7),
		.ay_bdir (ay_bdir),
		.ay_bc1  (ay_bc1),
		.sd_cs_n (sd_cs_n),
		.sd_req  (sd_req),
		.sd_tx   (sd_tx),
		.sd_ack  (sd_ack),
		.sd_rx   (sd_rx)
	);

	zx_sd_spi i_spi (
		.clk     (clk),
		.rst_n   (rst_n),
		.sd_req  (sd_req),
		.sd_tx   (sd_tx),
		.sd_ack  (sd_ack),
		.sd_rx   (sd_rx),
		.sd_sclk (sd_sclk),
		.sd_mosi (sd_mosi),
		.sd_miso (sd_miso)
	);

endmodule

`default_nettype wire

/* bench/zx_ports_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zx_ports_config.svh"

module zx_ports_tb
	import zx_ports_pkg::*;
();

	localparam int POLL_MAX = 16 * `ZXP_SPI_DIV + 16;

	logic        clk;
	logic        rst_n;
	z80_bus_t    bus;
	logic  [4:0] keys_in;
	logic  [4:0] kj_in;
	logic        sd_miso = 1'b1;
	wire   [7:0] dout;
	wire         dataout;
	wire   [2:0] border;
	wire         beep;
	wire         dos;
	wire   [7:0] p7ffd;
	wire   [7:0] peff7;
	wire         ay_bdir;
	wire         ay_bc1;
	wire         sd_cs_n;
	wire         sd_sclk;
	wire         sd_mosi;

	// reference model state
	logic  [2:0] m_border = 3'd0;
	logic        m_beep   = 1'b0;
	logic  [7:0] m_7ffd   = 8'h00;
	logic  [7:0] m_eff7   = 8'h00;
	logic        m_dos    = 1'b0;
	logic        m_cs_n   = 1'b1;
	logic  [7:0] m_sd     = 8'hFF;   // last byte from the card

	logic        sclk_q = 1'b0;
	logic  [7:0] card_next;          // byte the card sends in the next exchange
	logic  [7:0] card_byte;
	logic  [7:0] card_sr;
	logic  [7:0] card_rx;
	logic  [7:0] card_rx_last;
	logic  [7:0] card_tx_last;
	int          card_bits = 0;

	logic  [7:0] s_dout;             // sampled in the middle of the strobe
	logic        s_dataout;
	logic        s_bdir;
	logic        s_bc1;
	integer      seed = 32'hc87f;
	int          checks = 0;
	int          errors = 0;
	int          test_no = 1;
	int          test_base = 0;
	logic  [7:0] lo_tab [0:5] = '{`ZXP_PORT_FE, `ZXP_PORT_FD, `ZXP_PORT_F7,
		`ZXP_PORT_KJOY, `ZXP_PORT_SDCFG, 8'h3B};

	zx_ports_top i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// mode 0 card, next miso bit goes out once a rising sclk has been seen
	always @(posedge clk)
	begin : card
		logic [7:0] rx_next;
		sclk_q <= sd_sclk;
		if (!rst_n)
			card_bits <= 0;
		else if (sd_sclk && !sclk_q && !sd_cs_n)
		begin
			rx_next = {card_rx[6:0], sd_mosi};
			card_rx   <= rx_next;
			card_bits <= card_bits + 1;
			card_sr   <= {card_sr[6:0], 1'b1};
			sd_miso   <= card_sr[6];
			if (card_bits % 8 == 7)
			begin
				card_rx_last <= rx_next;
				card_tx_last <= card_byte;
			end
		end
		else if (card_bits % 8 == 0)
		begin
			card_byte <= card_next; // between bytes
			card_sr   <= card_next;
			sd_miso   <= card_next[7];
		end
	end

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] want);
		checks++;
		assert (got === want)
		else
		begin
			$display("[ERROR] %s: got %h, expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_regs();
		@(negedge clk);
		check_val("border", 8'(border), 8'(m_border));
		check_val("beep", 8'(beep), 8'(m_beep));
		check_val("p7ffd", p7ffd, m_eff7[2] ? {3'b000, m_7ffd[4:0]} : m_7ffd);
		check_val("peff7", peff7, m_eff7);
		check_val("dos", 8'(dos), 8'(m_dos));
		check_val("sd_cs_n", 8'(sd_cs_n), 8'(m_cs_n));
	endtask

	// strobe low for 4 cycles, then high for 2
	task automatic bus_io(input logic wr, input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		bus.a      <= addr;
		bus.din    <= data;
		bus.iorq_n <= 1'b0;
		bus.wr_n   <= !wr;
		bus.rd_n   <= wr;
		repeat (2) @(posedge clk);
		@(negedge clk);
		s_dout    = dout;
		s_dataout = dataout;
		s_bdir    = ay_bdir;
		s_bc1     = ay_bc1;
		repeat (2) @(posedge clk);
		bus.iorq_n <= 1'b1;
		bus.wr_n   <= 1'b1;
		bus.rd_n   <= 1'b1;
		@(posedge clk);
	endtask

	task automatic write_port(input logic [15:0] addr, input logic [7:0] d);
		bus_io(1'b1, addr, d);
		case (addr[7:0])
			`ZXP_PORT_FE:
			begin
				m_border = d[2:0];
				m_beep   = d[4];
			end
			`ZXP_PORT_FD:
				if (!addr[15] && !(m_7ffd[5] && m_eff7[2]))
					m_7ffd = d;      // locked while both bits are set
			`ZXP_PORT_F7:
				if (!addr[12])
					m_eff7 = d;
			`ZXP_PORT_SDCFG: m_cs_n = d[1];
			default: ;
		endcase
		check_regs();
	endtask

	// {dataout, dout} expected for a read, with the SD side idle
	function automatic logic [8:0] exp_read(input logic [15:0] addr);
		case (addr[7:0])
			`ZXP_PORT_FE:    return {1'b1, 3'b101, keys_in};
			`ZXP_PORT_FD:    return {!addr[15], 8'hFF};
			`ZXP_PORT_F7:    return {!addr[12], 8'hFF};
			`ZXP_PORT_KJOY:  return m_dos ? 9'h0FF : {1'b1, 3'b000, kj_in};
			`ZXP_PORT_SDCFG: return 9'h100;
			`ZXP_PORT_SDDAT: return {1'b1, m_sd};
			default:         return 9'h0FF;
		endcase
	endfunction

	task automatic read_port(input logic [15:0] addr);
		logic [8:0] want;
		bus_io(1'b0, addr, 8'h00);
		want = exp_read(addr);
		check_val("dout", s_dout, want[7:0]);
		check_val("dataout", 8'(s_dataout), 8'(want[8]));
		check_regs();
	endtask

	task automatic opcode_fetch(input logic [15:0] addr);
		@(posedge clk);
		bus.a      <= addr;
		bus.mreq_n <= 1'b0;
		bus.m1_n   <= 1'b0;
		bus.rd_n   <= 1'b0;
		repeat (2) @(posedge clk);
		bus.mreq_n <= 1'b1;
		bus.m1_n   <= 1'b1;
		bus.rd_n   <= 1'b1;
		@(posedge clk);
		if (addr[15:8] == `ZXP_DOS_PAGE && m_7ffd[4])
			m_dos = 1'b1;
		else if (addr[15:14] != 2'b00)
			m_dos = 1'b0;
		check_regs();
	endtask

	// poll the busy bit of port 77
	task automatic wait_sd_idle();
		int polls;
		polls = 0;
		bus_io(1'b0, {8'h00, `ZXP_PORT_SDCFG}, 8'h00);
		while (s_dout[7] && polls < POLL_MAX)
		begin
			polls++;
			bus_io(1'b0, {8'h00, `ZXP_PORT_SDCFG}, 8'h00);
		end
		if (s_dout[7])
		begin
			$display("timeout: SD exchange still busy after %0d polls of port 77", polls);
			errors++;
		end
		m_sd      = card_tx_last;
		card_next = 8'($random(seed));
	endtask

	task automatic finish_test(input string name);
		$display("test %0d %s: %0d errors", test_no, name, errors - test_base);
		test_no++;
		test_base = errors;
	endtask

	initial
	begin : main
		logic [7:0] d;
		logic [2:0] idx;
		int         bits0;
		rst_n     = 1'b0;
		bus       = {16'h0000, 8'h00, 5'b11111}; // all strobes inactive
		keys_in   = 5'd0;
		kj_in     = 5'd0;
		card_next = 8'($random(seed));
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		check_regs();

		for (int i = 0; i < 16; i++)
		begin
			write_port({8'($random(seed)), `ZXP_PORT_FE}, 8'($random(seed)));
			@(posedge clk);
			keys_in <= 5'($random(seed));
			kj_in   <= 5'($random(seed));
			idx = 3'($unsigned($random(seed)) % 6);
			read_port({8'($random(seed)), `ZXP_PORT_FE});
			read_port({8'($random(seed)), lo_tab[idx]});
		end
		finish_test("port FE and reads");

		for (int i = 0; i < 32; i++)
			write_port((($random(seed) & 1) != 0) ? 16'h7FFD : 16'hEFF7, 8'($random(seed)));
		finish_test("paging 7FFD/EFF7");

		write_port(16'hEFF7, 8'h00);
		for (int i = 0; i < 12; i++)
		begin
			@(posedge clk);
			kj_in <= 5'($random(seed));
			write_port(16'h7FFD, 8'($random(seed)) & 8'hDF); // bit 5 clear, no lock
			opcode_fetch({`ZXP_DOS_PAGE, 8'($random(seed))});
			read_port({8'($random(seed)), `ZXP_PORT_KJOY});
			opcode_fetch(16'($random(seed)) & 16'h3FFF);
			opcode_fetch(16'($random(seed)) | 16'h4000);
			read_port({8'($random(seed)), `ZXP_PORT_KJOY});
		end
		finish_test("DOS trap and joystick");

		for (int i = 0; i < 8; i++)
		begin
			bus_io(i[1], i[0] ? 16'hBFFD : 16'hFFFD, 8'($random(seed)));
			check_val("ay_bdir", 8'(s_bdir), 8'(i[1]));
			check_val("ay_bc1", 8'(s_bc1), 8'(!i[0]));   // a14 set only for FFFD
			check_val("dataout", 8'(s_dataout), 8'h00);
			check_regs();
		end
		finish_test("AY strobes");

		write_port(16'h0077, 8'h00);
		write_port(16'h0077, 8'h02);
		write_port(16'h0077, 8'h00);
		for (int i = 0; i < 4; i++)
		begin
			d = 8'($random(seed));
			write_port(16'h0057, d);
			wait_sd_idle();
			check_val("card_rx", card_rx_last, d);
			read_port(16'h0057);   // returns the card byte, then clocks out FF
			wait_sd_idle();
			check_val("card_rx", card_rx_last, 8'hFF);
		end
		finish_test("SD exchange");

		for (int i = 0; i < 4; i++)
		begin
			bits0 = card_bits;
			d = 8'($random(seed));
			write_port(16'h0057, d);
			write_port(16'h0057, ~d);   // lands while busy
			wait_sd_idle();
			check_val("card_bits", 8'(card_bits - bits0), 8'd8);
			check_val("card_rx", card_rx_last, d);
			read_port(16'h0057);
			wait_sd_idle();
		end
		finish_test("SD write while busy");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* zx_ports_top.f */
+incdir+include
verilog/zx_ports_pkg.sv
verilog/zx_ports_decode.sv
verilog/zx_ports_regs.sv
verilog/zx_sd_spi.sv
verilog/zx_ports_top.sv
bench/zx_ports_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the zx_ports testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f zx_ports_top.f --top-module zx_ports_tb

# the verdict comes from the printed result line
out=$(./obj_dir/Vzx_ports_tb) || true
echo "$out"
echo "$out" | grep -qx "sim passed"
